// File: Makefile
SIM = obj_dir/Vtb_mixer

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mixer -f vlog.f

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: coef_store.sv
// Program memory for the mixer, written by the host and read by the sequencer
module coef_store (
    input  logic                         ck,
    input  logic                         we,
    input  logic [mixer_pkg::ADDR_W-1:0] waddr,
    input  logic [mixer_pkg::INSTR_W-1:0] wdata,
    input  logic [mixer_pkg::ADDR_W-1:0] raddr,
    output logic [mixer_pkg::INSTR_W-1:0] rdata
);

    localparam int DEPTH = 1 << mixer_pkg::ADDR_W;

    logic [mixer_pkg::INSTR_W-1:0] mem [DEPTH];

    // Host write port
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, instruction valid the cycle after pc
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

// File: mac_ctl_if.sv
// Per-instruction MAC and SAVE control passed from the sequencer to the datapath
interface mac_ctl_if;

    // Accumulate this cycle
    logic mac_en;
    // Load instead of accumulate
    logic clear;
    logic subtract;

    // Write an output sample
    logic save_en;
    logic [mixer_pkg::FRAME_W-1:0] shift;
    logic [mixer_pkg::CHAN_W-1:0] out_chan;

    // Unsigned gain for the multiplier
    logic [mixer_pkg::SAMPLE_W-1:0] gain;

    modport seq (
        output mac_en,
        output clear,
        output subtract,
        output save_en,
        output shift,
        output out_chan,
        output gain
    );

    modport dp (
        input mac_en,
        input clear,
        input subtract,
        input save_en,
        input shift,
        input out_chan,
        input gain
    );

endinterface

// File: mac_datapath.sv
// Multiply-accumulate datapath with shift-and-truncate output stage
module mac_datapath (
    input  logic                                  ck,
    input  logic                                  reset,
    input  logic signed [mixer_pkg::SAMPLE_W-1:0] sample,
    mac_ctl_if.dp                                 ctl,
    output logic                                  out_we,
    output logic [mixer_pkg::CHAN_W-1:0]          out_chan,
    output logic [mixer_pkg::SAMPLE_W-1:0]        out_data
);

    // Multiplier operands widened to the full product width
    logic signed [mixer_pkg::PROD_W-1:0] sample_x;
    logic signed [mixer_pkg::PROD_W-1:0] gain_x;
    logic signed [mixer_pkg::PROD_W-1:0] product;

    // Accumulator path
    logic signed [mixer_pkg::ACC_W-1:0] addend;
    logic signed [mixer_pkg::ACC_W-1:0] base;
    logic signed [mixer_pkg::ACC_W-1:0] acc_next;
    logic signed [mixer_pkg::ACC_W-1:0] acc;

    // Save stage
    logic save_q;
    logic [mixer_pkg::FRAME_W-1:0] shift_q;
    logic [mixer_pkg::CHAN_W-1:0] chan_q;
    logic signed [mixer_pkg::ACC_W-1:0] scaled;

    assign sample_x = (mixer_pkg::PROD_W)'(sample);
    // Gain is unsigned so zero extend
    assign gain_x = $signed({{(mixer_pkg::SAMPLE_W + 1){1'b0}}, ctl.gain});
    assign product = sample_x * gain_x;

    assign addend = (mixer_pkg::ACC_W)'(product);
    assign base = ctl.clear ? '0 : acc;
    assign acc_next = ctl.subtract ? base - addend : base + addend;

    always_ff @(posedge ck) begin
        if (ctl.mac_en) begin
            acc <= acc_next;
        end
    end

    // SAVE reads the accumulator one cycle later, after the previous MAC lands
    always_ff @(posedge ck) begin
        if (reset) begin
            save_q <= 1'b0;
        end else begin
            save_q <= ctl.save_en;
        end
    end

    always_ff @(posedge ck) begin
        shift_q <= ctl.shift;
        chan_q <= ctl.out_chan;
    end

    // Arithmetic shift keeps the sign, then plain truncation
    assign scaled = acc >>> shift_q;

    always_ff @(posedge ck) begin
        if (reset) begin
            out_we <= 1'b0;
            out_chan <= '0;
            out_data <= '0;
        end else begin
            out_we <= save_q;
            if (save_q) begin
                out_chan <= chan_q;
                out_data <= scaled[mixer_pkg::SAMPLE_W-1:0];
            end
        end
    end

endmodule

// File: mix_sequencer.sv
// Fetches and decodes the mixing program and issues sample reads and MAC controls
module mix_sequencer (
    input  logic                          ck,
    input  logic                          reset,
    input  logic                          start,
    input  logic [mixer_pkg::FRAME_W-1:0] frame,
    output logic [mixer_pkg::ADDR_W-1:0]  pc,
    input  logic [mixer_pkg::INSTR_W-1:0] instr,
    output logic [mixer_pkg::ADDR_W-1:0]  smp_addr,
    output logic                          busy,
    output logic                          done,
    output logic                          error,
    mac_ctl_if.seq                        ctl
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DRAIN
    } state_t;

    state_t state;

    // Frame number held for the whole run
    logic [mixer_pkg::FRAME_W-1:0] frame_q;

    // Slot valid flags: pc issue, coef read, decode
    logic fetch_v;
    logic read_v;
    logic dec_v;

    logic [mixer_pkg::INSTR_W-1:0] instr_q;

    // Instruction fields
    mixer_pkg::opcode_t op;
    logic [mixer_pkg::FRAME_W-1:0] offset;
    logic [mixer_pkg::CHAN_W-1:0] chan;
    logic [mixer_pkg::SAMPLE_W-1:0] gain;
    logic [mixer_pkg::FRAME_W-1:0] src_frame;

    // Decoded opcode
    logic is_mac;
    logic is_clear;
    logic is_sub;
    logic is_save;
    logic is_halt;
    logic is_bad;
    logic stop;

    // Tracks the HALT slot through the datapath stages
    logic [2:0] halt_pipe;

    assign fetch_v = (state == S_RUN);
    assign busy = (state != S_IDLE);

    assign op = mixer_pkg::opcode_t'(instr_q[mixer_pkg::OP_LSB +: mixer_pkg::OP_W]);
    assign offset = instr_q[mixer_pkg::OFF_LSB +: mixer_pkg::FRAME_W];
    assign chan = instr_q[mixer_pkg::CHAN_LSB +: mixer_pkg::CHAN_W];
    assign gain = instr_q[mixer_pkg::GAIN_LSB +: mixer_pkg::SAMPLE_W];

    // Delayed frame wraps modulo 16
    assign src_frame = frame_q - offset;
    assign smp_addr = {src_frame, chan};

    always_comb begin
        is_mac = 1'b0;
        is_clear = 1'b0;
        is_sub = 1'b0;
        is_save = 1'b0;
        is_halt = 1'b0;
        is_bad = 1'b0;
        case (op)
            mixer_pkg::OP_NOOP: ;
            mixer_pkg::OP_SAVE: is_save = 1'b1;
            mixer_pkg::OP_MAC: is_mac = 1'b1;
            mixer_pkg::OP_MACZ: begin
                is_mac = 1'b1;
                is_clear = 1'b1;
            end
            mixer_pkg::OP_MACN: begin
                is_mac = 1'b1;
                is_sub = 1'b1;
            end
            mixer_pkg::OP_MACNZ: begin
                is_mac = 1'b1;
                is_clear = 1'b1;
                is_sub = 1'b1;
            end
            mixer_pkg::OP_HALT: is_halt = 1'b1;
            default: is_bad = 1'b1;
        endcase
    end

    // An illegal opcode ends the run like HALT
    assign stop = dec_v & (is_halt | is_bad);

    always_ff @(posedge ck) begin
        if (reset) begin
            state <= S_IDLE;
            pc <= '0;
            read_v <= 1'b0;
            dec_v <= 1'b0;
            halt_pipe <= '0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            // Kill the two younger slots already fetched behind a stop
            read_v <= fetch_v & ~stop;
            dec_v <= read_v & ~stop;
            halt_pipe <= {halt_pipe[1:0], stop};
            done <= halt_pipe[2];
            if (dec_v && is_bad) begin
                error <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_RUN;
                        pc <= '0;
                        error <= 1'b0;
                    end
                end
                S_RUN: begin
                    pc <= pc + 1'b1;
                    if (stop) begin
                        state <= S_DRAIN;
                    end
                end
                default: begin
                    // Wait for the last SAVE to leave the datapath
                    if (halt_pipe[2]) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state == S_IDLE && start) begin
            frame_q <= frame;
        end
        if (read_v) begin
            instr_q <= instr;
        end
    end

    // Controls meet the sample one cycle after decode
    always_ff @(posedge ck) begin
        if (reset) begin
            ctl.mac_en <= 1'b0;
            ctl.save_en <= 1'b0;
        end else begin
            ctl.mac_en <= dec_v & is_mac;
            ctl.save_en <= dec_v & is_save;
        end
    end

    always_ff @(posedge ck) begin
        ctl.clear <= is_clear;
        ctl.subtract <= is_sub;
        ctl.shift <= offset;
        ctl.out_chan <= gain[mixer_pkg::CHAN_W-1:0];
        ctl.gain <= gain;
    end

endmodule

// File: mixer_pkg.sv
// Shared widths, opcode encodings and instruction field positions for the audio mixer
package mixer_pkg;

    // Channel and frame index widths
    localparam int CHAN_W = 4;
    localparam int FRAME_W = 4;

    // Store address is {frame, chan}; program store uses the same width
    localparam int ADDR_W = FRAME_W + CHAN_W;

    // Datapath widths
    localparam int SAMPLE_W = 16;
    localparam int ACC_W = 40;
    localparam int PROD_W = 2 * SAMPLE_W + 1;

    // Instruction word and its fields, top to bottom
    localparam int INSTR_W = 32;
    localparam int OP_W = 8;
    localparam int OP_LSB = 24;
    localparam int OFF_LSB = 20;
    localparam int CHAN_LSB = 16;
    localparam int GAIN_LSB = 0;

    // Opcodes; bit 0 of a MAC selects clear, bit 1 selects subtract
    typedef enum logic [OP_W-1:0] {
        OP_NOOP  = 8'h00,
        OP_SAVE  = 8'h02,
        OP_MAC   = 8'h08,
        OP_MACZ  = 8'h09,
        OP_MACN  = 8'h0A,
        OP_MACNZ = 8'h0B,
        OP_HALT  = 8'h0F
    } opcode_t;

endpackage

// File: mixer_top.sv
// Top level of the audio mixing engine, connecting the stores, sequencer and datapath
module mixer_top (
    input  logic                                  ck,
    input  logic                                  reset,
    // Program load
    input  logic                                  prog_we,
    input  logic [mixer_pkg::ADDR_W-1:0]          prog_addr,
    input  logic [mixer_pkg::INSTR_W-1:0]         prog_data,
    // Sample load
    input  logic                                  smp_we,
    input  logic [mixer_pkg::ADDR_W-1:0]          smp_addr,
    input  logic signed [mixer_pkg::SAMPLE_W-1:0] smp_data,
    // Run control
    input  logic                                  start,
    input  logic [mixer_pkg::FRAME_W-1:0]         frame,
    output logic                                  done,
    output logic                                  busy,
    output logic                                  error,
    // Mixed output
    output logic                                  out_we,
    output logic [mixer_pkg::CHAN_W-1:0]          out_chan,
    output logic [mixer_pkg::SAMPLE_W-1:0]        out_data
);

    logic [mixer_pkg::ADDR_W-1:0] pc;
    logic [mixer_pkg::INSTR_W-1:0] instr;
    logic [mixer_pkg::ADDR_W-1:0] smp_raddr;
    logic signed [mixer_pkg::SAMPLE_W-1:0] sample;

    mac_ctl_if ctl ();

    coef_store u_coef (
        .ck    (ck),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc),
        .rdata (instr)
    );

    sample_store u_samples (
        .ck    (ck),
        .we    (smp_we),
        .waddr (smp_addr),
        .wdata (smp_data),
        .raddr (smp_raddr),
        .rdata (sample)
    );

    mix_sequencer u_seq (
        .ck       (ck),
        .reset    (reset),
        .start    (start),
        .frame    (frame),
        .pc       (pc),
        .instr    (instr),
        .smp_addr (smp_raddr),
        .busy     (busy),
        .done     (done),
        .error    (error),
        .ctl      (ctl.seq)
    );

    mac_datapath u_dp (
        .ck       (ck),
        .reset    (reset),
        .sample   (sample),
        .ctl      (ctl.dp),
        .out_we   (out_we),
        .out_chan (out_chan),
        .out_data (out_data)
    );

endmodule

// File: sample_store.sv
// Input sample memory of 16 frames by 16 channels, written by the host
module sample_store (
    input  logic                                ck,
    input  logic                                we,
    input  logic [mixer_pkg::ADDR_W-1:0]        waddr,
    input  logic signed [mixer_pkg::SAMPLE_W-1:0] wdata,
    input  logic [mixer_pkg::ADDR_W-1:0]        raddr,
    output logic signed [mixer_pkg::SAMPLE_W-1:0] rdata
);

    localparam int DEPTH = 1 << mixer_pkg::ADDR_W;

    // Address is {frame, chan}
    logic signed [mixer_pkg::SAMPLE_W-1:0] mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Sample goes straight on to the multiplier
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

// File: tb_mixer.sv
// Self-checking testbench for mixer_top; build from vlog.f with tb_mixer as the top module
module tb_mixer;

    localparam int TIMEOUT = 200;

    logic ck;
    logic reset;
    logic prog_we;
    logic [mixer_pkg::ADDR_W-1:0] prog_addr;
    logic [mixer_pkg::INSTR_W-1:0] prog_data;
    logic smp_we;
    logic [mixer_pkg::ADDR_W-1:0] smp_addr;
    logic signed [mixer_pkg::SAMPLE_W-1:0] smp_data;
    logic start;
    logic [mixer_pkg::FRAME_W-1:0] frame;
    logic done;
    logic busy;
    logic error;
    logic out_we;
    logic [mixer_pkg::CHAN_W-1:0] out_chan;
    logic [mixer_pkg::SAMPLE_W-1:0] out_data;

    // Host-side copies of both stores
    logic [mixer_pkg::INSTR_W-1:0] prog_mem [256];
    logic signed [mixer_pkg::SAMPLE_W-1:0] smp_mem [256];
    int prog_len;

    // Expected outputs, oldest first
    logic [mixer_pkg::CHAN_W-1:0] exp_chan [$];
    logic [mixer_pkg::SAMPLE_W-1:0] exp_data [$];
    int out_count;

    mixer_top dut_i (
        .ck        (ck),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .smp_we    (smp_we),
        .smp_addr  (smp_addr),
        .smp_data  (smp_data),
        .start     (start),
        .frame     (frame),
        .done      (done),
        .busy      (busy),
        .error     (error),
        .out_we    (out_we),
        .out_chan  (out_chan),
        .out_data  (out_data)
    );

    always #2 ck = ~ck;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    // Each strobe must match the head of the expected queue
    always @(posedge ck) begin : check_output
        if (!reset && out_we) begin
            assert (exp_data.size() > 0)
                else report_failure("out_we pulsed with no output expected");
            assert (out_chan == exp_chan[0])
                else report_failure($sformatf("MISMATCH out_chan: got %h expected %h",
                                              out_chan, exp_chan[0]));
            assert (out_data == exp_data[0])
                else report_failure($sformatf("MISMATCH out_data: got %h expected %h",
                                              out_data, exp_data[0]));
            void'(exp_chan.pop_front());
            void'(exp_data.pop_front());
            out_count++;
        end
    end

    assert property (@(posedge ck) disable iff (reset) out_we |-> busy)
        else report_failure("out_we pulsed outside a run");
    assert property (@(posedge ck) disable iff (reset) done |-> !busy)
        else report_failure("busy still high while done pulses");

    task automatic add_instr(input logic [7:0] op, input logic [3:0] offset,
                             input logic [3:0] chan, input logic [15:0] gain);
        prog_mem[prog_len] = (32'(op) << mixer_pkg::OP_LSB) | (32'(offset) << mixer_pkg::OFF_LSB)
                           | (32'(chan) << mixer_pkg::CHAN_LSB) | (32'(gain) << mixer_pkg::GAIN_LSB);
        prog_len++;
    endtask

    task automatic load_program();
        for (int a = 0; a < prog_len; a++) begin
            @(posedge ck);
            prog_we <= 1'b1;
            prog_addr <= a[7:0];
            prog_data <= prog_mem[a];
        end
        @(posedge ck);
        prog_we <= 1'b0;
    endtask

    task automatic write_sample(input logic [7:0] addr, input logic [15:0] data);
        @(posedge ck);
        smp_we <= 1'b1;
        smp_addr <= addr;
        smp_data <= data;
        smp_mem[addr] = data;
    endtask

    task automatic release_writes();
        @(posedge ck);
        smp_we <= 1'b0;
        prog_we <= 1'b0;
    endtask

    // Walks the program from address 0 and queues what each SAVE should output
    task automatic predict_outputs(input logic [3:0] run_frame);
        longint acc;
        longint s;
        longint g;
        longint scaled;
        logic [31:0] word;
        logic [7:0] op;
        logic [3:0] src;
        int addr;
        bit running;
        acc = 0;
        addr = 0;
        running = 1'b1;
        while (running && addr < 256) begin
            word = prog_mem[addr];
            op = word[31:24];
            if (op == mixer_pkg::OP_MAC || op == mixer_pkg::OP_MACZ ||
                op == mixer_pkg::OP_MACN || op == mixer_pkg::OP_MACNZ) begin
                // Offset counts frames back from the current one, modulo 16
                src = run_frame - word[23:20];
                s = smp_mem[{src, word[19:16]}];
                g = word[15:0];
                if (op == mixer_pkg::OP_MACZ || op == mixer_pkg::OP_MACNZ) begin
                    acc = 0;
                end
                if (op == mixer_pkg::OP_MACN || op == mixer_pkg::OP_MACNZ) begin
                    acc = acc - s * g;
                end else begin
                    acc = acc + s * g;
                end
                acc = (acc <<< 24) >>> 24;
            end else if (op == mixer_pkg::OP_SAVE) begin
                scaled = acc >>> word[23:20];
                exp_chan.push_back(word[3:0]);
                exp_data.push_back(scaled[15:0]);
            end else if (op != mixer_pkg::OP_NOOP) begin
                // HALT or an illegal opcode
                running = 1'b0;
            end
            addr++;
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == TIMEOUT) begin
                report_failure("Timed out waiting for done");
            end else begin
                @(posedge ck);
                cycles++;
            end
        end
    endtask

    task automatic run_mix(input logic [3:0] run_frame, input bit poke_busy);
        int want;
        int base;
        predict_outputs(run_frame);
        want = exp_data.size();
        base = out_count;
        @(posedge ck);
        start <= 1'b1;
        frame <= run_frame;
        @(posedge ck);
        start <= 1'b0;
        if (poke_busy) begin
            // A second start with another frame must change nothing
            @(posedge ck);
            assert (busy) else report_failure("busy not set during a run");
            start <= 1'b1;
            frame <= run_frame + 4'd5;
            @(posedge ck);
            start <= 1'b0;
        end
        wait_for_done();
        assert (!busy) else report_failure("busy still set after done");
        assert (out_count - base == want)
            else report_failure($sformatf("MISMATCH output count: got %h expected %h",
                                          out_count - base, want));
        repeat (4) @(posedge ck);
        assert (!busy) else report_failure("A run started without a start strobe");
    endtask

    initial begin
        logic [31:0] r;
        ck = 1'b0;
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        smp_we = 1'b0;
        smp_addr = '0;
        smp_data = '0;
        start = 1'b0;
        frame = '0;
        prog_len = 0;
        out_count = 0;
        void'($urandom(32'hd105));
        repeat (2) @(posedge ck);
        reset <= 1'b0;
        @(posedge ck);
        assert (!busy && !done && !out_we && !error && out_chan == 0 && out_data == 0)
            else report_failure("Outputs not cleared by reset");

        for (int a = 0; a < 256; a++) begin
            r = $urandom();
            write_sample(a[7:0], r[15:0]);
        end
        release_writes();

        // Single product, no shift
        add_instr(mixer_pkg::OP_MACZ, 4'd0, 4'd3, 16'hb6a3);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd5);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd6, 1'b0);

        // Chain over negative samples, then a scaled SAVE
        prog_len = 0;
        for (int i = 0; i < 5; i++) begin
            r = $urandom();
            write_sample({4'd9, r[3:0]}, {1'b1, r[18:4]});
            add_instr(i == 0 ? mixer_pkg::OP_MACZ : mixer_pkg::OP_MAC, 4'd0, r[3:0], r[31:16]);
        end
        release_writes();
        add_instr(mixer_pkg::OP_SAVE, 4'd7, 4'd0, 16'd2);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd9, 1'b0);

        // Equal add and subtract cancel; MACNZ drops the sum before it and negates
        r = $urandom();
        prog_len = 0;
        add_instr(mixer_pkg::OP_MACZ, 4'd0, 4'd2, r[15:0]);
        add_instr(mixer_pkg::OP_MACN, 4'd0, 4'd2, r[15:0]);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd1);
        add_instr(mixer_pkg::OP_MAC, 4'd0, 4'd4, 16'h4321);
        add_instr(mixer_pkg::OP_MACNZ, 4'd0, 4'd11, r[31:16]);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd8);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd3, 1'b0);

        // Frame 1 minus offset 3 wraps to frame 14
        prog_len = 0;
        add_instr(mixer_pkg::OP_MACZ, 4'd3, 4'd7, 16'd1);
        add_instr(mixer_pkg::OP_MAC, 4'd15, 4'd2, 16'd3);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd4);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd1, 1'b0);

        // Several SAVEs in order, with a start pulse mid-run
        prog_len = 0;
        add_instr(mixer_pkg::OP_MACZ, 4'd1, 4'd5, 16'h0321);
        add_instr(mixer_pkg::OP_SAVE, 4'd2, 4'd0, 16'd3);
        add_instr(mixer_pkg::OP_MAC, 4'd4, 4'd6, 16'h7fff);
        add_instr(mixer_pkg::OP_SAVE, 4'd4, 4'd0, 16'd9);
        add_instr(mixer_pkg::OP_MACN, 4'd0, 4'd1, 16'hffff);
        add_instr(mixer_pkg::OP_SAVE, 4'd1, 4'd0, 16'd12);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd12, 1'b1);

        // Illegal opcode ends the run and hides the SAVE after it
        prog_len = 0;
        add_instr(mixer_pkg::OP_MACZ, 4'd0, 4'd8, 16'h0040);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd6);
        add_instr(8'h55, 4'd0, 4'd0, 16'd0);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd7);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd0, 1'b0);
        assert (error) else report_failure("error not set by an illegal opcode");

        prog_len = 0;
        add_instr(mixer_pkg::OP_MACZ, 4'd0, 4'd3, 16'h0101);
        add_instr(mixer_pkg::OP_SAVE, 4'd0, 4'd0, 16'd5);
        add_instr(mixer_pkg::OP_HALT, 4'd0, 4'd0, 16'd0);
        load_program();
        run_mix(4'd2, 1'b0);
        assert (!error) else report_failure("error not cleared by the next start");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
mixer_pkg.sv
mac_ctl_if.sv
coef_store.sv
sample_store.sv
mix_sequencer.sv
mac_datapath.sv
mixer_top.sv
tb_mixer.sv
